// File: filelist.f
verilog/fetch_pkg.sv
verilog/fetch_pc_gen.sv
verilog/fetch_stage.sv
verilog/fetch_lane.sv
verilog/fetch_group_collect.sv
verilog/fetch_unit.sv
verification/fetch_tb_clock.sv
verification/fetch_tb.sv

// File: verification/fetch_tb.sv
module fetch_tb
	import fetch_pkg::*;
();

	localparam int LANES = 4;
	localparam int LINE_WORDS = 8;
	localparam int CNT_W = $clog2(LANES + 1);

	// One expected output group as the fetch rules describe it
	typedef struct packed {
		logic [LANES*INSN_W-1:0] insn;
		logic [LANES*PC_W-1:0]   pcs;
		logic [LANES-1:0]        branch;
		logic [CNT_W-1:0]        count;
	} group_t;

	logic                         clk;
	logic                         rst;
	logic                         en;
	logic                         ihit;
	logic                         nmi;
	logic                         redir;
	logic [PC_W-1:0]              redir_pc;
	logic [LINE_WORDS*INSN_W-1:0] ic_line;
	logic [PC_W-1:0]              line_base;
	logic [PC_W-1:0]              fetch_pc;
	logic [LANES*INSN_W-1:0]      grp_insn;
	logic [LANES*PC_W-1:0]        grp_pc;
	logic [LANES-1:0]             grp_branch;
	logic [CNT_W-1:0]             grp_count;
	logic                         grp_valid;

	// Expected groups in arrival order with the cycle each one is due
	logic [PC_W-1:0] exp_pc[$];
	int              exp_due[$];
	logic [PC_W-1:0] model_pc = RST_PC;
	logic [31:0]     key;
	int              seed;
	int              cyc = 0;
	int              ready_cnt = 0;
	int              errors = 0;
	int              err_start = 0;
	int              tests_run = 0;
	int              tests_failed = 0;
	int              groups_seen = 0;
	int              branch_seen = 0;
	string           test_name = "reset";

	fetch_tb_clock u_clock (.clk_o(clk));

	fetch_unit #(
		.LANES      (LANES),
		.LINE_WORDS (LINE_WORDS)
	) u_dut (
		.clk            (clk),
		.rst            (rst),
		.en_i           (en),
		.ihit_i         (ihit),
		.nmi_i          (nmi),
		.redirect_i     (redir),
		.redirect_pc_i  (redir_pc),
		.ic_line_i      (ic_line),
		.fetch_pc_o     (fetch_pc),
		.group_insn_o   (grp_insn),
		.group_pc_o     (grp_pc),
		.group_branch_o (grp_branch),
		.group_count_o  (grp_count),
		.group_valid_o  (grp_valid)
	);

	// ============================================================
	// Cache model and reference
	// ============================================================

	// Mixes the whole address with the run's random key into one word
	function automatic logic [INSN_W-1:0] word_at(input logic [PC_W-1:0] addr,
			input logic [31:0] salt);
		logic [31:0] h;
		h = (addr * 32'h9E37_79B1) ^ salt;
		h = h ^ (h >> 15);
		h = h * 32'h85EB_CA6B;
		// Roughly one word in four carries the branch opcode
		if (h[21:20] == 2'b00) begin
			h[OPC_W-1:0] = OPC_BRANCH;
		end
		return h;
	endfunction

	// The cache answers in the same cycle with the whole aligned line
	always_comb begin
		line_base = fetch_pc & ~PC_W'(LINE_WORDS * WORD_BYTES - 1);
		for (int k = 0; k < LINE_WORDS; k++) begin
			ic_line[k*INSN_W +: INSN_W] = word_at(line_base + PC_W'(k * WORD_BYTES), key);
		end
	end

	// A group at pc stops at the line end and lanes past it show a no-op
	function automatic group_t expect_group(input logic [PC_W-1:0] pc);
		group_t            g;
		int                left;
		logic [INSN_W-1:0] w;
		left = LINE_WORDS - int'((pc / WORD_BYTES) % LINE_WORDS);
		g.count = CNT_W'((left < LANES) ? left : LANES);
		for (int i = 0; i < LANES; i++) begin
			w = word_at(pc + PC_W'(i * WORD_BYTES), key);
			g.pcs[i*PC_W +: PC_W] = pc + PC_W'(i * WORD_BYTES);
			g.insn[i*INSN_W +: INSN_W] = (i < left) ? w : OP_NOP;
			g.branch[i] = (i < left) && (w[OPC_W-1:0] == OPC_BRANCH);
		end
		return g;
	endfunction

	task automatic note_mismatch(input string what, input logic [127:0] expv,
			input logic [127:0] actv);
		$display("mismatch %s %s expected %0h actual %0h", test_name, what, expv, actv);
		errors++;
	endtask

	// Cycle count and startup window that the falling edge samples
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (rst) begin
			ready_cnt <= 0;
		end else if (ready_cnt < STARTUP_CYCLES) begin
			ready_cnt <= ready_cnt + 1;
		end
	end

	// ============================================================
	// Compare process
	// ============================================================

	always @(negedge clk) begin : compare_proc
		group_t g;
		if (!rst && grp_valid) begin
			groups_seen++;
			if (exp_due.size() == 0 || exp_due[0] != cyc) begin
				$display("%s: a group at pc %0h arrived when none was due", test_name,
					grp_pc[PC_W-1:0]);
				errors++;
			end else begin
				g = expect_group(exp_pc.pop_front());
				void'(exp_due.pop_front());
				if (grp_count !== g.count) note_mismatch("count", g.count, grp_count);
				if (grp_pc !== g.pcs) note_mismatch("pc", g.pcs, grp_pc);
				if (grp_insn !== g.insn) note_mismatch("insn", g.insn, grp_insn);
				if (grp_branch !== g.branch) note_mismatch("branch", g.branch, grp_branch);
				for (int i = 0; i < LANES; i++) begin
					branch_seen += grp_branch[i];
				end
			end
		end else if (!rst && exp_due.size() > 0 && exp_due[0] == cyc) begin
			$display("%s: the group at pc %0h never appeared", test_name, exp_pc[0]);
			errors++;
			void'(exp_pc.pop_front());
			void'(exp_due.pop_front());
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================

	// Each call checks the address on one falling edge, drives the inputs and updates the model
	task automatic drive_cycle(input logic do_en, input logic do_hit, input logic do_nmi,
			input logic do_redir, input logic [PC_W-1:0] new_pc);
		int left;
		@(negedge clk);
		if (fetch_pc !== model_pc) note_mismatch("fetch_pc", model_pc, fetch_pc);
		en = do_en;
		ihit = do_hit;
		nmi = do_nmi;
		redir = do_redir;
		redir_pc = new_pc;
		left = LINE_WORDS - int'((model_pc / WORD_BYTES) % LINE_WORDS);
		if (do_redir) begin
			// Everything not yet out of the collector goes stale along with this cycle's take
			while (exp_due.size() > 0 && exp_due[exp_due.size()-1] > cyc) begin
				void'(exp_pc.pop_back());
				void'(exp_due.pop_back());
			end
			model_pc = new_pc;
		end else if (do_en && do_hit && !do_nmi && ready_cnt == STARTUP_CYCLES) begin
			exp_pc.push_back(model_pc);
			exp_due.push_back(cyc + 3);
			model_pc = model_pc + PC_W'(((left < LANES) ? left : LANES) * WORD_BYTES);
		end
	endtask

	task automatic drain();
		for (int n = 0; n < 16 && exp_due.size() > 0; n++) begin
			drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
		end
		if (exp_due.size() > 0) begin
			$display("%s: %0d groups still outstanding after the wait", test_name,
				exp_due.size());
			errors++;
		end
		// A stale group that escaped the stomp would show up here
		repeat (4) drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == err_start) begin
			$display("test %s passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, errors - err_start);
		end
	endtask

	initial begin
		int lat;
		int seen_before;
		int branch_before;
		seed = 13327;
		key = $urandom(seed);
		rst = 1'b1;
		en = 1'b0;
		ihit = 1'b0;
		nmi = 1'b0;
		redir = 1'b0;
		redir_pc = '0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		start_test("sequential");
		if (grp_valid !== 1'b0) begin
			$display("%s: group valid is high right after reset", test_name);
			errors++;
		end
		repeat (20) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drain();
		finish_test();

		// Offsets 6 and 7 leave two words and one word in the line
		start_test("partial");
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, 32'h0000_2018);
		repeat (2) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drain();
		drive_cycle(1'b0, 1'b1, 1'b0, 1'b1, 32'h0000_301C);
		repeat (2) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drain();
		finish_test();

		start_test("miss_and_nmi");
		repeat (40) drive_cycle(1'b1, ($urandom % 3) != 0, ($urandom % 6) == 0, 1'b0, '0);
		drain();
		finish_test();

		// A lone redirect and then two in a row while groups are in flight
		start_test("redirect");
		repeat (3) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, 32'h0000_4008);
		repeat (4) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, 32'h0000_5000);
		drive_cycle(1'b1, 1'b1, 1'b0, 1'b1, 32'h0000_6010);
		repeat (3) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drain();
		finish_test();

		start_test("branch_predecode");
		branch_before = branch_seen;
		repeat (24) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		drain();
		if (branch_seen == branch_before) begin
			$display("%s: no lane was flagged as a branch", test_name);
			errors++;
		end
		finish_test();

		start_test("latency");
		seen_before = groups_seen;
		lat = 0;
		drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, '0);
		for (int k = 1; k <= 10 && lat == 0; k++) begin
			drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, '0);
			if (grp_valid) lat = k;
		end
		if (lat == 0) begin
			$display("%s: no group arrived within 10 cycles", test_name);
			errors++;
		end else if (lat != 3) begin
			note_mismatch("edges", 3, lat);
		end
		drain();
		if (groups_seen - seen_before != 1) begin
			note_mismatch("groups", 1, groups_seen - seen_before);
		end
		finish_test();

		start_test("random_mix");
		repeat (80) begin
			drive_cycle(($urandom % 4) != 0, ($urandom % 4) != 0, ($urandom % 10) == 0,
				($urandom % 12) == 0, $urandom & 32'h0000_FFFC);
		end
		drain();
		finish_test();

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verification/fetch_tb_clock.sv
module fetch_tb_clock #(
	parameter int PERIOD = 8
) (
	output logic clk_o
);

	// Free running clock, low for the first half period
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD / 2) clk_o = ~clk_o;
		end
	end

endmodule

// File: verilog/fetch_group_collect.sv
module fetch_group_collect
	import fetch_pkg::*;
#(
	parameter int LANES = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [BNO_W-1:0]            cur_bno_i,
	input  logic [LANES*INSN_W-1:0]     lane_insn_i,
	input  logic [LANES*PC_W-1:0]       lane_pc_i,
	input  logic [LANES-1:0]            lane_valid_i,
	input  logic [BNO_W-1:0]            lane_bno_i,
	input  logic [LANES-1:0]            lane_branch_i,
	output logic [LANES*INSN_W-1:0]     group_insn_o,
	output logic [LANES*PC_W-1:0]       group_pc_o,
	output logic [LANES-1:0]            group_branch_o,
	output logic [$clog2(LANES+1)-1:0]  group_count_o,
	output logic                        group_valid_o
);

	localparam int CNT_W = $clog2(LANES + 1);

	logic [CNT_W-1:0]          lane_count;
	logic [CNT_W-1:0]          count_q;
	logic [LANES*INSN_W-1:0]   insn_q;
	logic [LANES*PC_W-1:0]     pc_q;
	logic [LANES-1:0]          branch_q;
	logic [BNO_W-1:0]          bno_q;

	// ==========================================================
	// Lane count
	// ==========================================================

	// Population count over the lane valid bits
	always_comb begin
		lane_count = '0;
		for (int i = 0; i < LANES; i++) begin
			lane_count = lane_count + CNT_W'(lane_valid_i[i]);
		end
	end

	// ==========================================================
	// Output group register
	// ==========================================================

	// An empty group leaves a zero count, which also means no group
	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
			branch_q <= '0;
		end else begin
			count_q <= lane_count;
			branch_q <= lane_branch_i;
		end
	end

	always_ff @(posedge clk) begin
		insn_q <= lane_insn_i;
		pc_q <= lane_pc_i;
		bno_q <= lane_bno_i;
	end

	assign group_insn_o = insn_q;
	assign group_pc_o = pc_q;
	assign group_branch_o = branch_q;
	assign group_count_o = count_q;

	// ==========================================================
	// Stomp
	// ==========================================================

	// The tag is checked against the live branch number after the register,
	// so a redirect kills every older group still inside the pipe
	assign group_valid_o = (count_q != '0) && (bno_q == cur_bno_i);

	// Valid lanes always fill from lane 0 upward with no holes
	property p_valid_prefix;
		@(posedge clk) disable iff (rst)
		(lane_valid_i & (lane_valid_i + LANES'(1))) == '0;
	endproperty
	a_valid_prefix: assert property (p_valid_prefix);

endmodule

// File: verilog/fetch_lane.sv
module fetch_lane
	import fetch_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [INSN_W-1:0] insn_i,
	input  logic [PC_W-1:0]   pc_i,
	input  logic              valid_i,
	input  logic [BNO_W-1:0]  bno_i,
	output logic [INSN_W-1:0] insn_o,
	output logic [PC_W-1:0]   pc_o,
	output logic              valid_o,
	output logic [BNO_W-1:0]  bno_o,
	output logic              branch_o
);

	logic [INSN_W-1:0] insn_q;
	logic [PC_W-1:0]   pc_q;
	logic [BNO_W-1:0]  bno_q;
	logic              valid_q;
	logic              branch_q;
	logic              is_branch;

	// ==========================================================
	// Predecode
	// ==========================================================

	// Only the major opcode is looked at here, an empty lane never flags
	assign is_branch = valid_i && (insn_i[OPC_W-1:0] == OPC_BRANCH);

	// ==========================================================
	// Lane register
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
			branch_q <= 1'b0;
		end else begin
			valid_q <= valid_i;
			branch_q <= is_branch;
		end
	end

	// Word, address and tag follow the valid bit without a reset
	always_ff @(posedge clk) begin
		insn_q <= insn_i;
		pc_q <= pc_i;
		bno_q <= bno_i;
	end

	// Empty lanes present a no-op so later stages see harmless code
	assign insn_o = valid_q ? insn_q : OP_NOP;
	assign pc_o = pc_q;
	assign valid_o = valid_q;
	assign bno_o = bno_q;
	assign branch_o = branch_q;

endmodule

// File: verilog/fetch_pc_gen.sv
module fetch_pc_gen
	import fetch_pkg::*;
#(
	parameter int LANES = 4,
	parameter int LINE_WORDS = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             en_i,
	input  logic             ihit_i,
	input  logic             nmi_i,
	input  logic             redirect_i,
	input  logic [PC_W-1:0]  redirect_pc_i,
	output logic [PC_W-1:0]  fetch_pc_o,
	output logic             take_o,
	output logic [BNO_W-1:0] cur_bno_o
);

	// Position of the word index inside the byte address
	localparam int OFF_LSB = $clog2(WORD_BYTES);
	localparam int OFF_W = $clog2(LINE_WORDS);
	// Wide enough to hold a full line's worth of words
	localparam int ADV_W = $clog2(LINE_WORDS + 1);
	localparam int CNT_W = $clog2(STARTUP_CYCLES + 1);

	logic [PC_W-1:0]  fetch_pc_q;
	logic [BNO_W-1:0] bno_q;
	logic [CNT_W-1:0] startup_cnt_q;
	logic             startup_done;
	logic [OFF_W-1:0] word_off;
	logic [ADV_W-1:0] words_left;
	logic [ADV_W-1:0] advance;

	// ==========================================================
	// Group advance
	// ==========================================================

	// Word slot of the current address within its cache line
	assign word_off = fetch_pc_q[OFF_LSB +: OFF_W];
	assign words_left = ADV_W'(LINE_WORDS) - ADV_W'(word_off);

	// A group stops at the line end, so near the end it is short
	assign advance = (words_left < ADV_W'(LANES)) ? words_left : ADV_W'(LANES);

	// ==========================================================
	// Startup window and take decision
	// ==========================================================

	// Counts up once after reset and then parks at the limit
	always_ff @(posedge clk) begin
		if (rst) begin
			startup_cnt_q <= '0;
		end else if (!startup_done) begin
			startup_cnt_q <= startup_cnt_q + 1'b1;
		end
	end

	assign startup_done = (startup_cnt_q == CNT_W'(STARTUP_CYCLES));

	// A miss or a pending interrupt leaves the cycle empty
	assign take_o = en_i && ihit_i && !nmi_i && startup_done;

	// ==========================================================
	// Address and branch number
	// ==========================================================

	// A redirect wins over a take in the same cycle, and the new branch
	// number makes the group taken alongside it stale
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc_q <= RST_PC;
			bno_q <= BNO_W'(1);
		end else if (redirect_i) begin
			fetch_pc_q <= redirect_pc_i;
			bno_q <= bno_q + 1'b1;
		end else if (take_o) begin
			fetch_pc_q <= fetch_pc_q + (PC_W'(advance) << OFF_LSB);
		end
	end

	assign fetch_pc_o = fetch_pc_q;
	assign cur_bno_o = bno_q;

	// An interrupt cycle takes nothing and the address holds over the edge
	property p_nmi_holds_fetch;
		@(posedge clk) disable iff (rst)
		(nmi_i && !redirect_i) |-> !take_o ##1 $stable(fetch_pc_o);
	endproperty
	a_nmi_holds_fetch: assert property (p_nmi_holds_fetch);

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

	// ==========================================================
	// Datapath widths
	// ==========================================================

	// Width of a fetch address in bits
	localparam int PC_W = 32;

	// Every instruction is one 32-bit word
	localparam int INSN_W = 32;

	// Bytes per instruction word, used for address stepping
	localparam int WORD_BYTES = 4;

	// Branch number width, the counter simply wraps
	localparam int BNO_W = 4;

	// Width of the major opcode field at the bottom of a word
	localparam int OPC_W = 7;

	// ==========================================================
	// Constants
	// ==========================================================

	// Fetch restarts here after reset, word aligned
	localparam logic [PC_W-1:0] RST_PC = 32'h0000_0100;

	// Encoding shown on lanes that carry no instruction
	localparam logic [INSN_W-1:0] OP_NOP = 32'h0000_0013;

	// Major opcode that predecode flags as a branch
	localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b110_0011;

	// Fetch stays off for this many cycles once reset drops
	localparam int STARTUP_CYCLES = 4;

endpackage

// File: verilog/fetch_stage.sv
module fetch_stage
	import fetch_pkg::*;
#(
	parameter int LANES = 4,
	parameter int LINE_WORDS = 8
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         take_i,
	input  logic [PC_W-1:0]              fetch_pc_i,
	input  logic [BNO_W-1:0]             cur_bno_i,
	input  logic [LINE_WORDS*INSN_W-1:0] ic_line_i,
	output logic [LANES*INSN_W-1:0]      lane_insn_o,
	output logic [LANES*PC_W-1:0]        lane_pc_o,
	output logic [LANES-1:0]             lane_valid_o,
	output logic [BNO_W-1:0]             grp_bno_o
);

	localparam int OFF_LSB = $clog2(WORD_BYTES);
	localparam int OFF_W = $clog2(LINE_WORDS);

	logic [OFF_W-1:0]          word_off;
	logic [LANES*INSN_W-1:0]   rot_words;
	logic [LANES-1:0]          valid_mask;

	// Registered group
	logic [LANES*INSN_W-1:0]   insn_q;
	logic [PC_W-1:0]           pc_q;
	logic [BNO_W-1:0]          bno_q;
	logic [LANES-1:0]          valid_q;

	// Word slot of the fetch address within the line
	assign word_off = fetch_pc_i[OFF_LSB +: OFF_W];

	// ==========================================================
	// Rotation and lane mask
	// ==========================================================

	for (genvar i = 0; i < LANES; i++) begin : g_lane_sel
		logic [OFF_W-1:0] src_idx;

		// Index wraps inside the line, the mask below hides wrapped words
		assign src_idx = word_off + OFF_W'(i);
		assign rot_words[i*INSN_W +: INSN_W] = ic_line_i[src_idx*INSN_W +: INSN_W];

		// Lane is real only while it still falls inside the line
		assign valid_mask[i] = (int'(word_off) + i) < LINE_WORDS;

		// Each lane sits one word further on from the group address
		assign lane_pc_o[i*PC_W +: PC_W] = pc_q + PC_W'(i * WORD_BYTES);
	end

	// ==========================================================
	// Group register
	// ==========================================================

	// An idle cycle sends an empty group down the pipe
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= take_i ? valid_mask : '0;
		end
	end

	// Payload only loads with a real group
	always_ff @(posedge clk) begin
		if (take_i) begin
			insn_q <= rot_words;
			pc_q <= fetch_pc_i;
			bno_q <= cur_bno_i;
		end
	end

	assign lane_insn_o = insn_q;
	assign lane_valid_o = valid_q;
	assign grp_bno_o = bno_q;

	// Any taken group carries at least its addressed word in lane 0
	property p_lane0_after_take;
		@(posedge clk) disable iff (rst)
		$past(take_i) |-> lane_valid_o[0];
	endproperty
	a_lane0_after_take: assert property (p_lane0_after_take);

endmodule

// File: verilog/fetch_unit.sv
module fetch_unit
	import fetch_pkg::*;
#(
	parameter int LANES = 4,
	parameter int LINE_WORDS = 8
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         en_i,
	input  logic                         ihit_i,
	input  logic                         nmi_i,
	input  logic                         redirect_i,
	input  logic [PC_W-1:0]              redirect_pc_i,
	input  logic [LINE_WORDS*INSN_W-1:0] ic_line_i,
	output logic [PC_W-1:0]              fetch_pc_o,
	output logic [LANES*INSN_W-1:0]      group_insn_o,
	output logic [LANES*PC_W-1:0]        group_pc_o,
	output logic [LANES-1:0]             group_branch_o,
	output logic [$clog2(LANES+1)-1:0]   group_count_o,
	output logic                         group_valid_o
);

	// Address generator to fetch stage
	logic                    take;
	logic [BNO_W-1:0]        cur_bno;

	// Fetch stage to lanes
	logic [LANES*INSN_W-1:0] st_insn;
	logic [LANES*PC_W-1:0]   st_pc;
	logic [LANES-1:0]        st_valid;
	logic [BNO_W-1:0]        st_bno;

	// Lanes to collector
	logic [LANES*INSN_W-1:0] ln_insn;
	logic [LANES*PC_W-1:0]   ln_pc;
	logic [LANES-1:0]        ln_valid;
	logic [LANES*BNO_W-1:0]  ln_bno;
	logic [LANES-1:0]        ln_branch;

	fetch_pc_gen #(
		.LANES      (LANES),
		.LINE_WORDS (LINE_WORDS)
	) u_pc_gen (
		.clk           (clk),
		.rst           (rst),
		.en_i          (en_i),
		.ihit_i        (ihit_i),
		.nmi_i         (nmi_i),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.fetch_pc_o    (fetch_pc_o),
		.take_o        (take),
		.cur_bno_o     (cur_bno)
	);

	fetch_stage #(
		.LANES      (LANES),
		.LINE_WORDS (LINE_WORDS)
	) u_stage (
		.clk          (clk),
		.rst          (rst),
		.take_i       (take),
		.fetch_pc_i   (fetch_pc_o),
		.cur_bno_i    (cur_bno),
		.ic_line_i    (ic_line_i),
		.lane_insn_o  (st_insn),
		.lane_pc_o    (st_pc),
		.lane_valid_o (st_valid),
		.grp_bno_o    (st_bno)
	);

	// One predecode register per lane
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		fetch_lane u_lane (
			.clk      (clk),
			.rst      (rst),
			.insn_i   (st_insn[i*INSN_W +: INSN_W]),
			.pc_i     (st_pc[i*PC_W +: PC_W]),
			.valid_i  (st_valid[i]),
			.bno_i    (st_bno),
			.insn_o   (ln_insn[i*INSN_W +: INSN_W]),
			.pc_o     (ln_pc[i*PC_W +: PC_W]),
			.valid_o  (ln_valid[i]),
			.bno_o    (ln_bno[i*BNO_W +: BNO_W]),
			.branch_o (ln_branch[i])
		);
	end

	// All lanes share one tag, lane 0 speaks for the group
	fetch_group_collect #(
		.LANES (LANES)
	) u_collect (
		.clk            (clk),
		.rst            (rst),
		.cur_bno_i      (cur_bno),
		.lane_insn_i    (ln_insn),
		.lane_pc_i      (ln_pc),
		.lane_valid_i   (ln_valid),
		.lane_bno_i     (ln_bno[BNO_W-1:0]),
		.lane_branch_i  (ln_branch),
		.group_insn_o   (group_insn_o),
		.group_pc_o     (group_pc_o),
		.group_branch_o (group_branch_o),
		.group_count_o  (group_count_o),
		.group_valid_o  (group_valid_o)
	);

endmodule
